/* source/opq_params.svh */
// Operand queue parameters
`ifndef OPQ_PARAMS_SVH
`define OPQ_PARAMS_SVH

// Width of one VRF word
`define OPQ_ELEN 64

// Queues in the stage
`define OPQ_NR_QUEUES 4

// Width of the output word count of a command
`define OPQ_VL_WIDTH 8

// Buffer depths
`define OPQ_CMD_DEPTH 4
`define OPQ_ALU_DATA_DEPTH 4
// Store and shared slide/addrgen queues
`define OPQ_ST_DATA_DEPTH 2

`endif

/* source/vec_elem_pkg.sv */
// Vector element types
`default_nettype none

`include "opq_params.svh"

package vec_elem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operand data
  ////////////////////////////////////////////////////////////////////////////

  // One operand word as read from the VRF
  typedef logic [`OPQ_ELEN-1:0] elen_t;

  ////////////////////////////////////////////////////////////////////////////
  // Element conversion
  ////////////////////////////////////////////////////////////////////////////

  // Extension opcodes produce the low element first, then the high one
  typedef enum logic [1:0] {
    CONV_NONE  = 2'd0,
    CONV_SEXT2 = 2'd1,
    CONV_ZEXT2 = 2'd2
  } conv_op_e;

endpackage : vec_elem_pkg

`default_nettype wire

/* source/lane_opq_pkg.sv */
// Lane operand queue types
`default_nettype none

package lane_opq_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Queue indices
  ////////////////////////////////////////////////////////////////////////////

  // Position of each queue in the stage's per-queue vectors
  typedef enum logic [1:0] {
    QUEUE_ALU_A    = 2'd0,
    QUEUE_ALU_B    = 2'd1,
    QUEUE_ST       = 2'd2,
    QUEUE_SLD_ADDR = 2'd3
  } opq_id_e;

  // Consumer of a word on the shared slide/addrgen queue
  typedef enum logic {
    TARGET_SLDU    = 1'b0,
    TARGET_ADDRGEN = 1'b1
  } target_fu_e;

endpackage : lane_opq_pkg

`default_nettype wire

/* source/opq_fifo.sv */
// Synchronous FIFO
`timescale 1ns/1ns
`default_nettype none

module opq_fifo #(
  parameter int unsigned Depth = 4,
  parameter int unsigned Width = 64
) (
  input  wire                           clk_i,
  input  wire                           rst_n_i,
  input  wire                           push_i,
  input  wire  [Width-1:0]              data_i,
  input  wire                           pop_i,
  output logic [Width-1:0]              data_o,
  output logic                          empty_o,
  output logic                          full_o,
  output logic [$clog2(Depth+1)-1:0]    usage_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  logic [Width-1:0]    mem_q [Depth];
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [CntWidth-1:0] cnt_q;

  // Head is visible without a read cycle
  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CntWidth'(Depth));
  assign usage_o = cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        // Depth need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(push_i && full_o))
    else $error("opq_fifo: push into a full buffer");

  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(pop_i && empty_o))
    else $error("opq_fifo: pop from an empty buffer");

endmodule : opq_fifo

`default_nettype wire

/* source/operand_queue.sv */
// Operand queue
`timescale 1ns/1ns
`default_nettype none

`include "opq_params.svh"

module operand_queue #(
  parameter int unsigned CmdBufDepth  = `OPQ_CMD_DEPTH,
  parameter int unsigned DataBufDepth = `OPQ_ALU_DATA_DEPTH
) (
  input  wire                           clk_i,
  input  wire                           rst_n_i,
  // Command from the operand requester
  input  wire                           cmd_valid_i,
  input  wire vec_elem_pkg::conv_op_e   cmd_conv_i,
  input  wire [`OPQ_VL_WIDTH-1:0]       cmd_vl_i,
  input  wire lane_opq_pkg::target_fu_e cmd_target_i,
  // VRF side
  input  wire vec_elem_pkg::elen_t      operand_i,
  input  wire                           operand_valid_i,
  input  wire                           operand_issued_i,
  output logic                          operand_queue_ready_o,
  // Functional unit side
  output vec_elem_pkg::elen_t           operand_o,
  output lane_opq_pkg::target_fu_e      operand_target_fu_o,
  output logic                          operand_valid_o,
  input  wire                           operand_ready_i
);

  import vec_elem_pkg::*;
  import lane_opq_pkg::*;

  localparam int unsigned ConvWidth  = $bits(conv_op_e);
  localparam int unsigned TgtWidth   = $bits(target_fu_e);
  localparam int unsigned CmdWidth   = ConvWidth + `OPQ_VL_WIDTH + TgtWidth;
  localparam int unsigned UsageWidth = $clog2(DataBufDepth + 1);
  localparam int unsigned HalfWidth  = `OPQ_ELEN / 2;

  ////////////////////////////////////////////////////////////////////////////
  // Command buffer
  ////////////////////////////////////////////////////////////////////////////

  logic [CmdWidth-1:0]      cmd_wdata;
  logic [CmdWidth-1:0]      cmd_head;
  logic                     cmd_empty;
  logic                     cmd_full;
  logic                     cmd_pop;
  conv_op_e                 head_conv;
  logic [`OPQ_VL_WIDTH-1:0] head_vl;
  target_fu_e               head_target;

  assign cmd_wdata = {cmd_conv_i, cmd_vl_i, cmd_target_i};

  opq_fifo #(
    .Depth(CmdBufDepth),
    .Width(CmdWidth   )
  ) i_cmd_buf (
    .clk_i  (clk_i      ),
    .rst_n_i(rst_n_i    ),
    .push_i (cmd_valid_i),
    .data_i (cmd_wdata  ),
    .pop_i  (cmd_pop    ),
    .data_o (cmd_head   ),
    .empty_o(cmd_empty  ),
    .full_o (cmd_full   ),
    .usage_o(           )
  );

  assign head_conv   = conv_op_e'(cmd_head[CmdWidth-1 -: ConvWidth]);
  assign head_vl     = cmd_head[TgtWidth +: `OPQ_VL_WIDTH];
  assign head_target = target_fu_e'(cmd_head[TgtWidth-1:0]);

  // The slide unit is the idle default
  assign operand_target_fu_o = cmd_empty ? TARGET_SLDU : head_target;

  ////////////////////////////////////////////////////////////////////////////
  // Data buffer and credits
  ////////////////////////////////////////////////////////////////////////////

  elen_t                 data_head;
  logic                  data_empty;
  logic                  data_pop;
  logic [UsageWidth-1:0] data_usage;
  logic [UsageWidth-1:0] inflight_q;

  opq_fifo #(
    .Depth(DataBufDepth),
    .Width(`OPQ_ELEN   )
  ) i_data_buf (
    .clk_i  (clk_i          ),
    .rst_n_i(rst_n_i        ),
    .push_i (operand_valid_i),
    .data_i (operand_i      ),
    .pop_i  (data_pop       ),
    .data_o (data_head      ),
    .empty_o(data_empty     ),
    .full_o (               ),
    .usage_o(data_usage     )
  );

  // Reads in flight already own a slot
  assign operand_queue_ready_o =
    ((UsageWidth + 1)'(data_usage) + (UsageWidth + 1)'(inflight_q)) <
    (UsageWidth + 1)'(DataBufDepth);

  ////////////////////////////////////////////////////////////////////////////
  // Extension datapath
  ////////////////////////////////////////////////////////////////////////////

  logic                     half_sel_q;
  logic [`OPQ_VL_WIDTH-1:0] out_cnt_q;
  logic [HalfWidth-1:0]     elem;
  logic                     extend;
  logic                     last_out;
  logic                     transfer;

  assign extend = (head_conv == CONV_SEXT2) || (head_conv == CONV_ZEXT2);
  assign elem   = half_sel_q ? data_head[`OPQ_ELEN-1:HalfWidth] : data_head[HalfWidth-1:0];

  always_comb begin
    case (head_conv)
      CONV_SEXT2: operand_o = {{HalfWidth{elem[HalfWidth-1]}}, elem};
      CONV_ZEXT2: operand_o = {{HalfWidth{1'b0}}, elem};
      default:    operand_o = data_head;
    endcase
  end

  assign operand_valid_o = !cmd_empty && !data_empty;
  assign transfer        = operand_valid_o && operand_ready_i;
  assign last_out        = (out_cnt_q == head_vl - 1'b1);

  // An odd count under extension drops the last high half
  assign cmd_pop  = transfer && last_out;
  assign data_pop = transfer && (!extend || half_sel_q || last_out);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      inflight_q <= '0;
      out_cnt_q  <= '0;
      half_sel_q <= 1'b0;
    end else begin
      case ({operand_issued_i, operand_valid_i})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
      if (transfer) begin
        if (last_out) begin
          out_cnt_q  <= '0;
          half_sel_q <= 1'b0;
        end else begin
          out_cnt_q  <= out_cnt_q + 1'b1;
          half_sel_q <= extend && !half_sel_q;
        end
      end
    end
  end

  a_cmd_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_valid_i |-> !cmd_full)
    else $error("operand_queue: command pushed while the command buffer is full");

  // Each VRF word answers an earlier issued read
  a_operand_expected : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    operand_valid_i |-> (inflight_q != '0))
    else $error("operand_queue: operand delivered without a read in flight");

endmodule : operand_queue

`default_nettype wire

/* source/operand_queues_stage.sv */
// Operand queues stage
`timescale 1ns/1ns
`default_nettype none

`include "opq_params.svh"

module operand_queues_stage (
  input  wire                                                clk_i,
  input  wire                                                rst_n_i,
  // Commands from the operand requester
  input  wire [`OPQ_NR_QUEUES-1:0]                           operand_queue_cmd_valid_i,
  input  wire vec_elem_pkg::conv_op_e [`OPQ_NR_QUEUES-1:0]   cmd_conv_i,
  input  wire [`OPQ_NR_QUEUES-1:0][`OPQ_VL_WIDTH-1:0]        cmd_vl_i,
  input  wire lane_opq_pkg::target_fu_e [`OPQ_NR_QUEUES-1:0] cmd_target_i,
  // VRF reads
  input  wire vec_elem_pkg::elen_t [`OPQ_NR_QUEUES-1:0]      operand_i,
  input  wire [`OPQ_NR_QUEUES-1:0]                           operand_valid_i,
  input  wire [`OPQ_NR_QUEUES-1:0]                           operand_issued_i,
  output logic [`OPQ_NR_QUEUES-1:0]                          operand_queue_ready_o,
  // ALU
  output vec_elem_pkg::elen_t [1:0]                          alu_operand_o,
  output logic [1:0]                                         alu_operand_valid_o,
  input  wire [1:0]                                          alu_operand_ready_i,
  // Store unit
  output vec_elem_pkg::elen_t                                stu_operand_o,
  output logic                                               stu_operand_valid_o,
  input  wire                                                stu_operand_ready_i,
  // Slide unit and address generation
  output vec_elem_pkg::elen_t                                sldu_addrgen_operand_o,
  output lane_opq_pkg::target_fu_e                           sldu_addrgen_target_fu_o,
  output logic                                               sldu_addrgen_operand_valid_o,
  input  wire                                                sldu_operand_ready_i,
  input  wire                                                addrgen_operand_ready_i
);

  import lane_opq_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // ALU queues
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : gen_alu_queue
    // ALU A and ALU B sit at consecutive indices
    localparam opq_id_e Q = opq_id_e'(QUEUE_ALU_A + i);

    operand_queue #(
      .CmdBufDepth (`OPQ_CMD_DEPTH     ),
      .DataBufDepth(`OPQ_ALU_DATA_DEPTH)
    ) i_operand_queue_alu (
      .clk_i                (clk_i                       ),
      .rst_n_i              (rst_n_i                     ),
      .cmd_valid_i          (operand_queue_cmd_valid_i[Q]),
      .cmd_conv_i           (cmd_conv_i[Q]               ),
      .cmd_vl_i             (cmd_vl_i[Q]                 ),
      .cmd_target_i         (cmd_target_i[Q]             ),
      .operand_i            (operand_i[Q]                ),
      .operand_valid_i      (operand_valid_i[Q]          ),
      .operand_issued_i     (operand_issued_i[Q]         ),
      .operand_queue_ready_o(operand_queue_ready_o[Q]    ),
      .operand_o            (alu_operand_o[i]            ),
      .operand_target_fu_o  (                            ),
      .operand_valid_o      (alu_operand_valid_o[i]      ),
      .operand_ready_i      (alu_operand_ready_i[i]      )
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Store queue
  ////////////////////////////////////////////////////////////////////////////

  operand_queue #(
    .CmdBufDepth (`OPQ_CMD_DEPTH    ),
    .DataBufDepth(`OPQ_ST_DATA_DEPTH)
  ) i_operand_queue_st (
    .clk_i                (clk_i                                ),
    .rst_n_i              (rst_n_i                              ),
    .cmd_valid_i          (operand_queue_cmd_valid_i[QUEUE_ST]  ),
    .cmd_conv_i           (cmd_conv_i[QUEUE_ST]                 ),
    .cmd_vl_i             (cmd_vl_i[QUEUE_ST]                   ),
    .cmd_target_i         (cmd_target_i[QUEUE_ST]               ),
    .operand_i            (operand_i[QUEUE_ST]                  ),
    .operand_valid_i      (operand_valid_i[QUEUE_ST]            ),
    .operand_issued_i     (operand_issued_i[QUEUE_ST]           ),
    .operand_queue_ready_o(operand_queue_ready_o[QUEUE_ST]      ),
    .operand_o            (stu_operand_o                        ),
    .operand_target_fu_o  (                                     ),
    .operand_valid_o      (stu_operand_valid_o                  ),
    .operand_ready_i      (stu_operand_ready_i                  )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Shared slide/addrgen queue
  ////////////////////////////////////////////////////////////////////////////

  // Only the unit named by the head command may take a word
  logic sldu_ready_filt;
  logic addrgen_ready_filt;
  logic shared_ready;

  assign sldu_ready_filt    = sldu_operand_ready_i &
                              (sldu_addrgen_target_fu_o == TARGET_SLDU);
  assign addrgen_ready_filt = addrgen_operand_ready_i &
                              (sldu_addrgen_target_fu_o == TARGET_ADDRGEN);
  assign shared_ready       = sldu_ready_filt | addrgen_ready_filt;

  operand_queue #(
    .CmdBufDepth (`OPQ_CMD_DEPTH    ),
    .DataBufDepth(`OPQ_ST_DATA_DEPTH)
  ) i_operand_queue_sld_addr (
    .clk_i                (clk_i                                     ),
    .rst_n_i              (rst_n_i                                   ),
    .cmd_valid_i          (operand_queue_cmd_valid_i[QUEUE_SLD_ADDR] ),
    .cmd_conv_i           (cmd_conv_i[QUEUE_SLD_ADDR]                ),
    .cmd_vl_i             (cmd_vl_i[QUEUE_SLD_ADDR]                  ),
    .cmd_target_i         (cmd_target_i[QUEUE_SLD_ADDR]              ),
    .operand_i            (operand_i[QUEUE_SLD_ADDR]                 ),
    .operand_valid_i      (operand_valid_i[QUEUE_SLD_ADDR]           ),
    .operand_issued_i     (operand_issued_i[QUEUE_SLD_ADDR]          ),
    .operand_queue_ready_o(operand_queue_ready_o[QUEUE_SLD_ADDR]     ),
    .operand_o            (sldu_addrgen_operand_o                    ),
    .operand_target_fu_o  (sldu_addrgen_target_fu_o                  ),
    .operand_valid_o      (sldu_addrgen_operand_valid_o              ),
    .operand_ready_i      (shared_ready                              )
  );

endmodule : operand_queues_stage

`default_nettype wire

/* sim/opq_tb_model.svh */
// Operand queue testbench model
`ifndef OPQ_TB_MODEL_SVH
`define OPQ_TB_MODEL_SVH

localparam int NUM_TESTS = 5;

function automatic string test_name(input int idx);
  case (idx)
    0:       return "reset_state";
    1:       return "alu_a_pass_through";
    2:       return "alu_b_extension";
    3:       return "store_back_pressure";
    default: return "shared_queue_filter";
  endcase
endfunction

// Rough cycle budget of each test
function automatic int test_length(input int idx);
  case (idx)
    0:       return 16;
    1:       return 10;
    2:       return 13;
    3:       return 12;
    default: return 13;
  endcase
endfunction

function automatic int total_test_length();
  int sum;
  int i;
  sum = 0;
  for (i = 0; i < NUM_TESTS; i++) begin
    sum += test_length(i);
  end
  return sum;
endfunction

// Output word k of a command from the input word that holds it
function automatic elen_t ref_word(input elen_t in_word, input conv_op_e conv,
                                   input int unsigned k);
  logic [31:0] elem;
  elem = k[0] ? in_word[63:32] : in_word[31:0];
  case (conv)
    CONV_SEXT2: return {{32{elem[31]}}, elem};
    CONV_ZEXT2: return {32'h0, elem};
    default:    return in_word;
  endcase
endfunction

// Queue the VRF words and expected outputs of one command and then strobe it
task automatic load_command(input opq_id_e q, input conv_op_e conv,
                            input int unsigned vl, input target_fu_e tgt);
  elen_t       words[$];
  int unsigned n_in;
  int unsigned k;
  // An odd count under extension leaves the last high half unused
  n_in = (conv == CONV_NONE) ? vl : (vl + 1) / 2;
  for (k = 0; k < n_in; k++) begin
    words.push_back({$random(seed), $random(seed)});
    src_words[q].push_back(words[k]);
  end
  for (k = 0; k < vl; k++) begin
    exp_words[q].push_back(ref_word(words[(conv == CONV_NONE) ? k : k / 2], conv, k));
  end
  @(posedge clk_i);
  #1;
  operand_queue_cmd_valid_i[q] = 1'b1;
  cmd_conv_i[q]                = conv;
  cmd_vl_i[q]                  = vl[`OPQ_VL_WIDTH-1:0];
  cmd_target_i[q]              = tgt;
  @(posedge clk_i);
  #1;
  operand_queue_cmd_valid_i[q] = 1'b0;
endtask

// VRF driver where each word follows its read by one cycle
task automatic feed_vrf(input opq_id_e q);
  elen_t pend_word;
  logic  pend;
  pend      = 1'b0;
  pend_word = '0;
  while (src_words[q].size() > 0 || pend) begin
    @(posedge clk_i);
    #1;
    operand_valid_i[q]  = pend;
    operand_i[q]        = pend_word;
    operand_issued_i[q] = 1'b0;
    pend                = 1'b0;
    if (src_words[q].size() > 0 && operand_queue_ready_o[q]) begin
      operand_issued_i[q] = 1'b1;
      pend_word           = src_words[q].pop_front();
      pend                = 1'b1;
    end
  end
  @(posedge clk_i);
  #1;
  operand_valid_i[q] = 1'b0;
endtask

`endif

/* sim/operand_queues_stage_tb.sv */
// Operand queues stage testbench
`timescale 1ns/1ns
`default_nettype none

`include "opq_params.svh"

module operand_queues_stage_tb;

  import vec_elem_pkg::*;
  import lane_opq_pkg::*;

  localparam int RESET_CYCLES = 16;

  logic                                         clk_i;
  logic                                         rst_n_i;
  logic [`OPQ_NR_QUEUES-1:0]                    operand_queue_cmd_valid_i;
  conv_op_e [`OPQ_NR_QUEUES-1:0]                cmd_conv_i;
  logic [`OPQ_NR_QUEUES-1:0][`OPQ_VL_WIDTH-1:0] cmd_vl_i;
  target_fu_e [`OPQ_NR_QUEUES-1:0]              cmd_target_i;
  elen_t [`OPQ_NR_QUEUES-1:0]                   operand_i;
  logic [`OPQ_NR_QUEUES-1:0]                    operand_valid_i;
  logic [`OPQ_NR_QUEUES-1:0]                    operand_issued_i;
  logic [`OPQ_NR_QUEUES-1:0]                    operand_queue_ready_o;
  elen_t [1:0]                                  alu_operand_o;
  logic [1:0]                                   alu_operand_valid_o;
  logic [1:0]                                   alu_operand_ready_i;
  elen_t                                        stu_operand_o;
  logic                                         stu_operand_valid_o;
  logic                                         stu_operand_ready_i;
  elen_t                                        sldu_addrgen_operand_o;
  target_fu_e                                   sldu_addrgen_target_fu_o;
  logic                                         sldu_addrgen_operand_valid_o;
  logic                                         sldu_operand_ready_i;
  logic                                         addrgen_operand_ready_i;

  // Model state and bookkeeping
  integer seed = 58060;
  elen_t  src_words[`OPQ_NR_QUEUES][$];
  elen_t  exp_words[`OPQ_NR_QUEUES][$];
  logic   stu_random_en;
  int     cur_test;
  int     err_cnt;
  int     check_cnt;
  int     pass_cnt;
  int     fail_cnt;
  int     test_err_base;
  int     test_chk_base;

  `include "opq_tb_model.svh"

  operand_queues_stage dut_i (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic port_valid(input opq_id_e q);
    case (q)
      QUEUE_ALU_A: return alu_operand_valid_o[0];
      QUEUE_ALU_B: return alu_operand_valid_o[1];
      QUEUE_ST:    return stu_operand_valid_o;
      default:     return sldu_addrgen_operand_valid_o;
    endcase
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR in %s: %s", test_name(cur_test), msg);
    err_cnt++;
  endtask

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    check_cnt++;
    if (exp !== act) begin
      $display("MISMATCH %s: %s expected %h actual %h", test_name(cur_test), what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic sample_port(input opq_id_e q, input logic valid, input logic ready,
                             input elen_t data);
    if (valid && ready) begin
      if (exp_words[q].size() == 0) begin
        report_error($sformatf("%s delivered a word that was never expected", q.name()));
      end else begin
        check_value($sformatf("%s word", q.name()), exp_words[q].pop_front(), data);
      end
    end
  endtask

  // Outputs are sampled mid-cycle and transfer at the next rising edge
  initial begin : compare_proc
    logic shared_ready;
    forever begin
      @(negedge clk_i);
      shared_ready = (sldu_addrgen_target_fu_o == TARGET_SLDU) ? sldu_operand_ready_i
                                                              : addrgen_operand_ready_i;
      if (rst_n_i) begin
        sample_port(QUEUE_ALU_A, alu_operand_valid_o[0], alu_operand_ready_i[0],
                    alu_operand_o[0]);
        sample_port(QUEUE_ALU_B, alu_operand_valid_o[1], alu_operand_ready_i[1],
                    alu_operand_o[1]);
        sample_port(QUEUE_ST, stu_operand_valid_o, stu_operand_ready_i, stu_operand_o);
        sample_port(QUEUE_SLD_ADDR, sldu_addrgen_operand_valid_o, shared_ready,
                    sldu_addrgen_operand_o);
      end
    end
  end

  initial begin : stu_ready_gen
    integer rnd;
    forever begin
      @(posedge clk_i);
      #1;
      if (stu_random_en) begin
        rnd                 = $random(seed);
        stu_operand_ready_i = rnd[0];
      end else begin
        stu_operand_ready_i = 1'b0;
      end
    end
  end

  task automatic wait_words(input opq_id_e q, input int remaining);
    while (exp_words[q].size() > remaining) begin
      @(posedge clk_i);
    end
  endtask

  // No extra or duplicated word after the last expected one
  task automatic check_idle(input opq_id_e q);
    @(negedge clk_i);
    check_cnt++;
    if (port_valid(q)) begin
      report_error($sformatf("%s still presents a word after the last one", q.name()));
    end
  endtask

  task automatic run_queue(input opq_id_e q);
    fork
      feed_vrf(q);
      wait_words(q, 0);
    join
    check_idle(q);
  endtask

  // Head word must stay put while only the other unit is ready
  task automatic hold_check(input target_fu_e tgt);
    int i;
    do begin
      @(negedge clk_i);
    end while (!sldu_addrgen_operand_valid_o);
    for (i = 0; i < 4; i++) begin
      check_value("held valid", 64'(1), 64'(sldu_addrgen_operand_valid_o));
      check_value("target", 64'(tgt), 64'(sldu_addrgen_target_fu_o));
      check_value("held word", exp_words[QUEUE_SLD_ADDR][0], sldu_addrgen_operand_o);
      @(negedge clk_i);
    end
  endtask

  task automatic idle_queue(input opq_id_e q);
    cmd_conv_i[q]   = CONV_NONE;
    cmd_target_i[q] = TARGET_SLDU;
  endtask

  task automatic start_test(input int idx);
    cur_test      = idx;
    test_err_base = err_cnt;
    test_chk_base = check_cnt;
  endtask

  task automatic finish_test();
    int errs;
    errs = err_cnt - test_err_base;
    if (errs == 0) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    $display("%-22s %-6s checks %0d errors %0d", test_name(cur_test),
             (errs == 0) ? "ok" : "FAILED", check_cnt - test_chk_base, errs);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_proc
    operand_queue_cmd_valid_i = '0;
    cmd_vl_i                  = '0;
    operand_i                 = '0;
    operand_valid_i           = '0;
    operand_issued_i          = '0;
    idle_queue(QUEUE_ALU_A);
    idle_queue(QUEUE_ALU_B);
    idle_queue(QUEUE_ST);
    idle_queue(QUEUE_SLD_ADDR);
    alu_operand_ready_i       = 2'b00;
    stu_operand_ready_i       = 1'b0;
    sldu_operand_ready_i      = 1'b0;
    addrgen_operand_ready_i   = 1'b0;
    stu_random_en             = 1'b0;
    err_cnt                   = 0;
    check_cnt                 = 0;
    pass_cnt                  = 0;
    fail_cnt                  = 0;
    cur_test                  = 0;
    rst_n_i                   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    start_test(0);
    @(negedge clk_i);
    check_value("ALU valids", 64'(0), 64'(alu_operand_valid_o));
    check_value("store valid", 64'(0), 64'(stu_operand_valid_o));
    check_value("shared valid", 64'(0), 64'(sldu_addrgen_operand_valid_o));
    check_value("VRF readies", 64'({`OPQ_NR_QUEUES{1'b1}}), 64'(operand_queue_ready_o));
    check_value("shared target", 64'(TARGET_SLDU), 64'(sldu_addrgen_target_fu_o));
    finish_test();

    start_test(1);
    @(posedge clk_i);
    #1;
    alu_operand_ready_i = 2'b11;
    load_command(QUEUE_ALU_A, CONV_NONE, 10, TARGET_SLDU);
    run_queue(QUEUE_ALU_A);
    finish_test();

    // Odd zero-extended count, then a plain command right behind it
    start_test(2);
    load_command(QUEUE_ALU_B, CONV_SEXT2, 6, TARGET_SLDU);
    load_command(QUEUE_ALU_B, CONV_ZEXT2, 5, TARGET_SLDU);
    load_command(QUEUE_ALU_B, CONV_NONE, 2, TARGET_SLDU);
    run_queue(QUEUE_ALU_B);
    finish_test();

    start_test(3);
    @(negedge clk_i);
    stu_random_en = 1'b1;
    load_command(QUEUE_ST, CONV_NONE, 12, TARGET_SLDU);
    run_queue(QUEUE_ST);
    stu_random_en = 1'b0;
    finish_test();

    start_test(4);
    @(posedge clk_i);
    #1;
    addrgen_operand_ready_i = 1'b1;
    load_command(QUEUE_SLD_ADDR, CONV_NONE, 2, TARGET_SLDU);
    load_command(QUEUE_SLD_ADDR, CONV_ZEXT2, 3, TARGET_ADDRGEN);
    fork
      feed_vrf(QUEUE_SLD_ADDR);
      begin
        hold_check(TARGET_SLDU);
        @(posedge clk_i);
        #1;
        sldu_operand_ready_i    = 1'b1;
        addrgen_operand_ready_i = 1'b0;
        wait_words(QUEUE_SLD_ADDR, 3);
        hold_check(TARGET_ADDRGEN);
        @(posedge clk_i);
        #1;
        addrgen_operand_ready_i = 1'b1;
        wait_words(QUEUE_SLD_ADDR, 0);
      end
    join
    check_idle(QUEUE_SLD_ADDR);
    finish_test();

    $display("Summary: %0d of %0d tests ok, %0d failed, %0d checks, %0d errors",
             pass_cnt, NUM_TESTS, fail_cnt, check_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (4 * total_test_length()) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles",
             4 * total_test_length());
    $display("Test failures found");
    $finish;
  end

endmodule : operand_queues_stage_tb

`default_nettype wire

/* operand_queues_stage.f */
+incdir+source
+incdir+sim
source/vec_elem_pkg.sv
source/lane_opq_pkg.sv
source/opq_fifo.sv
source/operand_queue.sv
source/operand_queues_stage.sv
sim/operand_queues_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= operand_queues_stage_tb
FILELIST  ?= operand_queues_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# The run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
